// File: hdl/decode_pkg.sv
// decode stage package
// opcodes, fixed register numbers and the bundles carried through the decode/execute latch
package decode_pkg;

	// alu operations
	localparam logic [4:0] OP_ADD  = 5'b00000;
	localparam logic [4:0] OP_ADDI = 5'b00001;
	localparam logic [4:0] OP_SUB  = 5'b00010;
	localparam logic [4:0] OP_SUBI = 5'b00011;
	localparam logic [4:0] OP_AND  = 5'b00100;
	localparam logic [4:0] OP_OR   = 5'b00101;
	localparam logic [4:0] OP_XOR  = 5'b00110;
	localparam logic [4:0] OP_NEG  = 5'b00111;
	localparam logic [4:0] OP_SLL  = 5'b01000;
	localparam logic [4:0] OP_SLR  = 5'b01001;
	localparam logic [4:0] OP_SAR  = 5'b01010;

	// memory operations
	localparam logic [4:0] OP_LD   = 5'b01011;
	localparam logic [4:0] OP_LDI  = 5'b01100;
	localparam logic [4:0] OP_ST   = 5'b01101;
	localparam logic [4:0] OP_STI  = 5'b01110;

	localparam logic [4:0] OP_NOP  = 5'b01111;

	// flow control
	localparam logic [4:0] OP_BEQ  = 5'b10000;
	localparam logic [4:0] OP_BNE  = 5'b10001;
	localparam logic [4:0] OP_BON  = 5'b10010;
	localparam logic [4:0] OP_BNN  = 5'b10011;
	localparam logic [4:0] OP_J    = 5'b10100;
	localparam logic [4:0] OP_JR   = 5'b10101;
	localparam logic [4:0] OP_JAL  = 5'b10110;

	// return from interrupt sits at the top of the opcode space
	localparam logic [4:0] OP_RIN  = 5'b11111;

	// registers that software cannot write through the file
	localparam logic [4:0] REG_ZERO = 5'd0;
	localparam logic [4:0] REG_LR   = 5'd30;
	localparam logic [4:0] REG_FL   = 5'd31;

	// upper half of every jump target, start of instruction memory
	localparam logic [15:0] JUMP_PREFIX = 16'h0600;

	typedef struct packed {
		logic [1:0] alu_src;
		logic [4:0] alu_op;
		logic       branch;
		logic       jump;
		logic       mem_wrt;
		logic       mem_en;
		logic [1:0] result_sel;
		logic       reg_wrt_en;
		logic [4:0] reg_wrt_sel;
		logic       lr_read;
		logic       lr_write;
		logic       fl_read;
		logic       fl_write;
		logic       illegal;
	} ctrl_t;

	typedef struct packed {
		logic [31:0] pc_next;
		logic [31:0] reg_1_data;
		logic [31:0] reg_2_data;
		logic [31:0] imm;
	} operand_t;

	// nothing enabled, used for flush
	localparam ctrl_t CTRL_BUBBLE = '0;

endpackage

// File: hdl/special_reg_if.sv
// special register update bus
// carries LR/FL write requests and interrupt restore values
`timescale 1ns/10ps

interface special_reg_if;
	logic        lr_write;
	logic [31:0] lr_wrt_data;
	logic        fl_write;
	logic [1:0]  fl_wrt_data;
	// interrupt return
	logic        restore;
	logic [31:0] lr_saved;
	logic [1:0]  fl_saved;

	modport src (
		output lr_write, lr_wrt_data,
		output fl_write, fl_wrt_data,
		output restore, lr_saved, fl_saved
	);

	modport dst (
		input lr_write, lr_wrt_data,
		input fl_write, fl_wrt_data,
		input restore, lr_saved, fl_saved
	);

endinterface

// File: hdl/reg_file_bypass.sv
// general register file, 32 x 32, two reads and one write
// same-cycle writes are forwarded to the read ports
`timescale 1ns/10ps

module reg_file_bypass (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [4:0]  rd1_sel,
	input  logic [4:0]  rd2_sel,
	input  logic        wr_en,
	input  logic [4:0]  wr_sel,
	input  logic [31:0] wr_data,
	output logic [31:0] rd1_data,
	output logic [31:0] rd2_data
);

	logic [31:0] regs [32];
	logic        wr_ok;

	// R0, LR and FL slots are never written here
	assign wr_ok = wr_en
		&& (wr_sel != decode_pkg::REG_ZERO)
		&& (wr_sel != decode_pkg::REG_LR)
		&& (wr_sel != decode_pkg::REG_FL);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= 32'd0;
			end
		end else if (wr_ok) begin
			regs[wr_sel] <= wr_data;
		end
	end

	// read port 1
	always_comb begin
		if (rd1_sel == decode_pkg::REG_ZERO) begin
			rd1_data = 32'd0;
		end else if (wr_ok && (wr_sel == rd1_sel)) begin
			rd1_data = wr_data;
		end else begin
			rd1_data = regs[rd1_sel];
		end
	end

	// read port 2
	always_comb begin
		if (rd2_sel == decode_pkg::REG_ZERO) begin
			rd2_data = 32'd0;
		end else if (wr_ok && (wr_sel == rd2_sel)) begin
			rd2_data = wr_data;
		end else begin
			rd2_data = regs[rd2_sel];
		end
	end

	// the zero register must hold across every cycle
	a_r0_zero: assert property (
		@(posedge clk) disable iff (!rst_n)
		regs[0] == 32'd0
	) else $error("register 0 changed to %h", regs[0]);

endmodule

// File: hdl/special_regs.sv
// link and flag registers
// restore from saved copies beats a plain write, which beats hold
`timescale 1ns/10ps

module special_regs (
	input  logic              clk,
	input  logic              rst_n,
	special_reg_if.dst        upd,
	output logic [31:0]       lr,
	output logic [1:0]        fl
);

	logic [31:0] lr_next;
	logic [1:0]  fl_next;

	always_comb begin
		lr_next = lr;
		fl_next = fl;
		if (upd.restore) begin
			lr_next = upd.lr_saved;
			fl_next = upd.fl_saved;
		end else begin
			if (upd.lr_write) lr_next = upd.lr_wrt_data;
			if (upd.fl_write) fl_next = upd.fl_wrt_data;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			lr <= 32'd0;
			fl <= 2'd0;
		end else begin
			lr <= lr_next;
			fl <= fl_next;
		end
	end

	// interrupt return brings back the saved link value
	a_lr_restore: assert property (
		@(posedge clk) disable iff (!rst_n)
		upd.restore |=> (lr == $past(upd.lr_saved))
	) else $error("lr not restored, got %h", lr);

	a_fl_known: assert property (
		@(posedge clk) disable iff (!rst_n)
		!$isunknown(fl)
	) else $error("fl is unknown");

endmodule

// File: hdl/control_decoder.sv
// instruction decoder
// turns an opcode into the control bundle and builds the immediate
`timescale 1ns/10ps

module control_decoder (
	input  logic [31:0]       instr,
	output decode_pkg::ctrl_t ctrl,
	output logic [31:0]       imm
);

	logic [4:0] opcode;
	logic [4:0] rd;
	logic [4:0] rs1;
	logic [4:0] rs2;
	logic       use_rs1;
	logic       use_rs2;

	assign opcode = instr[31:27];
	assign rd     = instr[26:22];
	assign rs1    = instr[21:17];
	assign rs2    = instr[16:12];

	always_comb begin
		ctrl         = decode_pkg::CTRL_BUBBLE;
		ctrl.alu_src = 2'd1;
		ctrl.alu_op  = opcode;
		imm          = 32'd0;
		use_rs1      = 1'b0;
		use_rs2      = 1'b0;

		case (opcode)
			decode_pkg::OP_ADD, decode_pkg::OP_SUB,
			decode_pkg::OP_AND, decode_pkg::OP_OR,
			decode_pkg::OP_XOR, decode_pkg::OP_SLL,
			decode_pkg::OP_SLR, decode_pkg::OP_SAR: begin
				ctrl.reg_wrt_en  = 1'b1;
				ctrl.reg_wrt_sel = rd;
				ctrl.fl_write    = 1'b1;
				use_rs1          = 1'b1;
				use_rs2          = 1'b1;
			end
			decode_pkg::OP_NEG: begin
				ctrl.reg_wrt_en  = 1'b1;
				ctrl.reg_wrt_sel = rd;
				ctrl.fl_write    = 1'b1;
				use_rs1          = 1'b1;
			end
			decode_pkg::OP_ADDI, decode_pkg::OP_SUBI: begin
				ctrl.alu_src     = 2'd0;
				// 12 bit signed immediate
				imm              = {{20{instr[11]}}, instr[11:0]};
				ctrl.reg_wrt_en  = 1'b1;
				ctrl.reg_wrt_sel = rd;
				ctrl.fl_write    = 1'b1;
				use_rs1          = 1'b1;
			end
			decode_pkg::OP_LD: begin
				ctrl.mem_en      = 1'b1;
				ctrl.result_sel  = 2'b01;
				ctrl.reg_wrt_en  = 1'b1;
				ctrl.reg_wrt_sel = rd;
				ctrl.fl_write    = 1'b1;
				use_rs1          = 1'b1;
			end
			decode_pkg::OP_LDI: begin
				ctrl.alu_src     = 2'd0;
				imm              = {16'd0, instr[15:0]};
				ctrl.mem_en      = 1'b1;
				ctrl.result_sel  = 2'b01;
				ctrl.reg_wrt_en  = 1'b1;
				ctrl.reg_wrt_sel = rd;
				ctrl.fl_write    = 1'b1;
			end
			decode_pkg::OP_ST: begin
				ctrl.mem_en  = 1'b1;
				ctrl.mem_wrt = 1'b1;
				use_rs1      = 1'b1;
			end
			decode_pkg::OP_STI: begin
				ctrl.alu_src = 2'd0;
				imm          = {16'd0, instr[15:0]};
				ctrl.mem_en  = 1'b1;
				ctrl.mem_wrt = 1'b1;
				use_rs1      = 1'b1;
			end
			decode_pkg::OP_NOP, decode_pkg::OP_RIN: begin
				ctrl = decode_pkg::CTRL_BUBBLE;
			end
			// conditional branches always look at the flags
			decode_pkg::OP_BEQ, decode_pkg::OP_BNE,
			decode_pkg::OP_BON, decode_pkg::OP_BNN: begin
				ctrl.branch     = 1'b1;
				ctrl.result_sel = 2'b10;
				ctrl.fl_read    = 1'b1;
				use_rs1         = 1'b1;
			end
			decode_pkg::OP_J: begin
				ctrl.alu_src    = 2'd0;
				ctrl.jump       = 1'b1;
				// word index inside instruction memory
				imm             = {decode_pkg::JUMP_PREFIX, instr[13:0], 2'b00};
				ctrl.result_sel = 2'b10;
			end
			decode_pkg::OP_JR: begin
				ctrl.jump       = 1'b1;
				ctrl.result_sel = 2'b10;
				use_rs1         = 1'b1;
			end
			decode_pkg::OP_JAL: begin
				ctrl.alu_src    = 2'd0;
				ctrl.jump       = 1'b1;
				imm             = {decode_pkg::JUMP_PREFIX, instr[13:0], 2'b00};
				ctrl.result_sel = 2'b10;
				ctrl.lr_write   = 1'b1;
			end
			default: begin
				// undefined opcode, everything high
				ctrl = '1;
				imm  = 32'hFFFF_FFFF;
			end
		endcase

		// sources that name the link or flag register
		ctrl.lr_read = ctrl.lr_read
			| (use_rs1 && (rs1 == decode_pkg::REG_LR))
			| (use_rs2 && (rs2 == decode_pkg::REG_LR));
		ctrl.fl_read = ctrl.fl_read
			| (use_rs1 && (rs1 == decode_pkg::REG_FL))
			| (use_rs2 && (rs2 == decode_pkg::REG_FL));
	end

	always_comb begin
		a_branch_jump: assert (!(ctrl.branch && ctrl.jump) || ctrl.illegal)
			else $error("branch and jump both set for opcode %b", opcode);
	end

endmodule

// File: hdl/pipe_latch.sv
// decode/execute pipeline register
// loads every cycle, the bubble value replaces the input on flush
`timescale 1ns/10ps

module pipe_latch #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     flush,
	input  payload_t d,
	input  payload_t bubble,
	output payload_t q
);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			q <= '0;
		end else if (flush) begin
			q <= bubble;
		end else begin
			q <= d;
		end
	end

endmodule

// File: hdl/decode_stage.sv
// instruction decode stage
// decoder, register file, LR/FL and the decode/execute latches
`timescale 1ns/10ps

module decode_stage (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [31:0] instr,
	input  logic [31:0] pc_next_in,
	input  logic        reg_wrt_en,
	input  logic [4:0]  reg_wrt_sel,
	input  logic [31:0] reg_wrt_data,
	input  logic        lr_write_in,
	input  logic [31:0] lr_wrt_data,
	input  logic        fl_write_in,
	input  logic [1:0]  fl_wrt_data,
	input  logic        restore,
	input  logic [31:0] lr_before_int,
	input  logic [1:0]  fl_before_int,
	input  logic        flush,
	output logic [31:0] pc_next_out,
	output logic [31:0] reg_1_data,
	output logic [31:0] reg_2_data,
	output logic [31:0] imm,
	output logic [31:0] lr,
	output logic [1:0]  fl,
	output logic [1:0]  alu_src,
	output logic [4:0]  alu_op,
	output logic        branch,
	output logic        jump,
	output logic        mem_wrt,
	output logic        mem_en,
	output logic [1:0]  result_sel,
	output logic        next_reg_wrt_en,
	output logic [4:0]  next_reg_wrt_sel,
	output logic        lr_read,
	output logic        lr_write,
	output logic        fl_read,
	output logic        fl_write,
	output logic        illegal
);

	decode_pkg::ctrl_t    ctrl_d;
	decode_pkg::ctrl_t    ctrl_q;
	decode_pkg::operand_t opnd_d;
	decode_pkg::operand_t opnd_q;

	special_reg_if sp_upd ();

	assign sp_upd.lr_write    = lr_write_in;
	assign sp_upd.lr_wrt_data = lr_wrt_data;
	assign sp_upd.fl_write    = fl_write_in;
	assign sp_upd.fl_wrt_data = fl_wrt_data;
	assign sp_upd.restore     = restore;
	assign sp_upd.lr_saved    = lr_before_int;
	assign sp_upd.fl_saved    = fl_before_int;

	control_decoder u_dec (
		.instr (instr),
		.ctrl  (ctrl_d),
		.imm   (opnd_d.imm)
	);

	reg_file_bypass u_rf (
		.clk      (clk),
		.rst_n    (rst_n),
		.rd1_sel  (instr[21:17]),
		.rd2_sel  (instr[16:12]),
		.wr_en    (reg_wrt_en),
		.wr_sel   (reg_wrt_sel),
		.wr_data  (reg_wrt_data),
		.rd1_data (opnd_d.reg_1_data),
		.rd2_data (opnd_d.reg_2_data)
	);

	special_regs u_sp (
		.clk   (clk),
		.rst_n (rst_n),
		.upd   (sp_upd.dst),
		.lr    (lr),
		.fl    (fl)
	);

	assign opnd_d.pc_next = pc_next_in;

	pipe_latch #(.payload_t(decode_pkg::ctrl_t)) u_ctrl_latch (
		.clk    (clk),
		.rst_n  (rst_n),
		.flush  (flush),
		.d      (ctrl_d),
		.bubble (decode_pkg::CTRL_BUBBLE),
		.q      (ctrl_q)
	);

	// operands keep flowing during flush
	pipe_latch #(.payload_t(decode_pkg::operand_t)) u_opnd_latch (
		.clk    (clk),
		.rst_n  (rst_n),
		.flush  (1'b0),
		.d      (opnd_d),
		.bubble ('0),
		.q      (opnd_q)
	);

	assign pc_next_out      = opnd_q.pc_next;
	assign reg_1_data       = opnd_q.reg_1_data;
	assign reg_2_data       = opnd_q.reg_2_data;
	assign imm              = opnd_q.imm;
	assign alu_src          = ctrl_q.alu_src;
	assign alu_op           = ctrl_q.alu_op;
	assign branch           = ctrl_q.branch;
	assign jump             = ctrl_q.jump;
	assign mem_wrt          = ctrl_q.mem_wrt;
	assign mem_en           = ctrl_q.mem_en;
	assign result_sel       = ctrl_q.result_sel;
	assign next_reg_wrt_en  = ctrl_q.reg_wrt_en;
	assign next_reg_wrt_sel = ctrl_q.reg_wrt_sel;
	assign lr_read          = ctrl_q.lr_read;
	assign lr_write         = ctrl_q.lr_write;
	assign fl_read          = ctrl_q.fl_read;
	assign fl_write         = ctrl_q.fl_write;
	assign illegal          = ctrl_q.illegal;

endmodule

// File: bench/clk_gen.sv
// testbench clock and reset source
// 8 ns clock, reset held low for the first 5 cycles
`timescale 1ns/10ps

module clk_gen (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk   = 1'b0;
		rst_n = 1'b0;
		repeat (5) @(posedge clk);
		#1 rst_n = 1'b1;
	end

	always #4 clk = ~clk;

endmodule

// File: bench/decode_tb.sv
// decode stage testbench
// replays the test table, one step per cycle, and checks the latched outputs
`timescale 1ns/10ps

module decode_tb;

	logic        clk, rst_n;
	logic [31:0] instr, pc_next_in, reg_wrt_data, lr_wrt_data, lr_before_int;
	logic        reg_wrt_en, lr_write_in, fl_write_in, restore, flush;
	logic [4:0]  reg_wrt_sel;
	logic [1:0]  fl_wrt_data, fl_before_int;
	logic [31:0] pc_next_out, reg_1_data, reg_2_data, imm, lr;
	logic [1:0]  fl, alu_src, result_sel;
	logic [4:0]  alu_op, next_reg_wrt_sel;
	logic        branch, jump, mem_wrt, mem_en, next_reg_wrt_en;
	logic        lr_read, lr_write, fl_read, fl_write, illegal;

	string       op_q[$];
	logic [31:0] instr_q[$], pc_q[$], a_q[$], b_q[$];
	string       e_ctrl[$], e_imm[$], e_r1[$], e_r2[$], e_pc[$], e_lr[$], e_fl[$];
	int          errors = 0;
	int          checks = 0;
	int          n_steps = 0;
	bit          loaded = 1'b0;

	clk_gen u_clk (.clk(clk), .rst_n(rst_n));

	decode_stage UUT (.*);

	task automatic set_idle();
		instr         = 32'h7800_0000;
		pc_next_in    = 32'd0;
		reg_wrt_en    = 1'b0;
		reg_wrt_sel   = 5'd0;
		reg_wrt_data  = 32'd0;
		lr_write_in   = 1'b0;
		lr_wrt_data   = 32'd0;
		fl_write_in   = 1'b0;
		fl_wrt_data   = 2'd0;
		restore       = 1'b0;
		lr_before_int = 32'd0;
		fl_before_int = 2'd0;
		flush         = 1'b0;
	endtask

	task automatic drive_step(input int i);
		set_idle();
		instr      = instr_q[i];
		pc_next_in = pc_q[i];
		case (op_q[i])
			"instr": ;
			"regwrite": begin
				reg_wrt_en   = 1'b1;
				reg_wrt_sel  = a_q[i][4:0];
				reg_wrt_data = b_q[i];
			end
			"spwrite": begin
				lr_write_in = 1'b1;
				lr_wrt_data = a_q[i];
				fl_write_in = 1'b1;
				fl_wrt_data = b_q[i][1:0];
			end
			// write requests carry other values, the saved copies must win
			"restore": begin
				restore       = 1'b1;
				lr_before_int = a_q[i];
				fl_before_int = b_q[i][1:0];
				lr_write_in   = 1'b1;
				lr_wrt_data   = ~a_q[i];
				fl_write_in   = 1'b1;
				fl_wrt_data   = ~b_q[i][1:0];
			end
			"flush": flush = 1'b1;
			default: begin
				errors++;
				$display("step %0d has an unknown operation %s", i, op_q[i]);
			end
		endcase
	endtask

	task automatic check_field(input int step, input string name, input string exp,
			input logic [31:0] got);
		logic [31:0] want;
		if (exp != "-") begin
			void'($sscanf(exp, "%h", want));
			checks++;
			assert (got === want) else begin
				errors++;
				$display("CHECK FAILED at %0t: step %0d %s expected %h got %h",
					$time, step, name, want, got);
			end
		end
	endtask

	task automatic check_step(input int i);
		logic [31:0] ctrl_word;
		ctrl_word = {8'd0, alu_src, alu_op, branch, jump, mem_wrt, mem_en, result_sel,
			next_reg_wrt_en, next_reg_wrt_sel, lr_read, lr_write, fl_read, fl_write, illegal};
		check_field(i, "ctrl", e_ctrl[i], ctrl_word);
		check_field(i, "imm", e_imm[i], imm);
		check_field(i, "reg_1_data", e_r1[i], reg_1_data);
		check_field(i, "reg_2_data", e_r2[i], reg_2_data);
		check_field(i, "pc_next_out", e_pc[i], pc_next_out);
		check_field(i, "lr", e_lr[i], lr);
		check_field(i, "fl", e_fl[i], {30'd0, fl});
	endtask

	task automatic load_tests(output bit ok);
		int          fd;
		int          cnt;
		string       line, op, s[7];
		logic [31:0] v_instr, v_pc, v_a, v_b;
		ok = 1'b0;
		fd = $fopen("bench/decode_tests.txt", "r");
		if (fd == 0) return;
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() == 0 || line.getc(0) == 8'h23) continue;
			cnt = $sscanf(line, "%s %h %h %h %h %s %s %s %s %s %s %s", op, v_instr, v_pc,
				v_a, v_b, s[0], s[1], s[2], s[3], s[4], s[5], s[6]);
			if (cnt != 12) continue;
			op_q.push_back(op);
			instr_q.push_back(v_instr);
			pc_q.push_back(v_pc);
			a_q.push_back(v_a);
			b_q.push_back(v_b);
			e_ctrl.push_back(s[0]);
			e_imm.push_back(s[1]);
			e_r1.push_back(s[2]);
			e_r2.push_back(s[3]);
			e_pc.push_back(s[4]);
			e_lr.push_back(s[5]);
			e_fl.push_back(s[6]);
		end
		$fclose(fd);
		ok = (op_q.size() > 0);
	endtask

	// watchdog sized from the number of steps
	initial begin
		wait (loaded);
		#((n_steps + 20) * 8);
		$display("run timed out before all test steps finished");
		$display("=== FAIL ===");
		$finish;
	end

	initial begin
		bit ok;
		set_idle();
		load_tests(ok);
		if (!ok) begin
			$display("could not read any test steps from bench/decode_tests.txt");
			$display("=== FAIL ===");
			$finish;
		end else begin
			n_steps = op_q.size();
			loaded  = 1'b1;
			wait (rst_n);
			// step i is driven while step i-1 sits in the latches
			for (int i = 0; i <= n_steps; i++) begin
				@(posedge clk);
				#1;
				if (i < n_steps) drive_step(i);
				else set_idle();
				#6;
				if (i > 0) check_step(i - 1);
			end
			$display("errors: %0d of %0d checks", errors, checks);
			if (errors == 0) begin
				$display("=== PASS ===");
			end else begin
				$display("=== FAIL ===");
			end
			$finish;
		end
	end

endmodule

// File: bench/decode_tests.txt
# op instr pc a b, then expected ctrl imm reg_1 reg_2 pc_next lr fl, hex, - is not checked
# a b: regwrite is sel data, spwrite and restore are lr fl, other ops ignore them
instr    780BF000 00000004 0 0        000000 00000000 00000000 00000000 00000004 00000000 0
regwrite 00CA5000 00000008 5 12345678 400462 00000000 12345678 12345678 00000008 - -
instr    110A0000 0000000C 0 0        440482 00000000 12345678 00000000 0000000C - -
regwrite 00400000 00000010 0 DEADBEEF 400422 00000000 00000000 00000000 00000010 - -
regwrite 20BDF000 00000014 1E CAFEF00D 480456 00000000 00000000 00000000 00000014 - -
regwrite 307FE000 00000018 1F 0BADF00D 4C0436 00000000 00000000 00000000 00000018 - -
instr    29FDF000 0000001C 0 0        4A04F6 00000000 00000000 00000000 0000001C - -
instr    098A0800 00000020 0 0        0204C2 FFFFF800 12345678 00000000 00000020 - -
instr    188A07FF 00000024 0 0        060442 000007FF 12345678 00000000 00000024 - -
instr    3A3E0000 00000028 0 0        4E0506 00000000 00000000 00000000 00000028 - -
instr    404A5000 0000002C 0 0        500422 00000000 12345678 12345678 0000002C - -
instr    5A4A0000 00000030 0 0        562D22 00000000 12345678 00000000 00000030 - -
instr    6280BEEF 00000034 0 0        182D42 0000BEEF 00000000 00000000 00000034 - -
instr    680A0000 00000038 0 0        5A6000 00000000 12345678 00000000 00000038 - -
instr    703C1234 0000003C 0 0        1C6010 00001234 00000000 00000000 0000003C - -
instr    800A0000 00000040 0 0        611004 00000000 12345678 00000000 00000040 - -
instr    880A0000 00000044 0 0        631004 00000000 12345678 00000000 00000044 - -
instr    A0003FFF 00000048 0 0        289000 0600FFFC 00000000 00000000 00000048 - -
instr    B0000123 0000004C 0 0        2C9008 0600048C 00000000 00000000 0000004C - -
instr    A80A0000 00000050 0 0        6A9000 00000000 12345678 00000000 00000050 - -
instr    F83C0000 00000054 0 0        000000 00000000 00000000 00000000 00000054 - -
spwrite  78000000 00000058 ABC 2      000000 00000000 - - 00000058 00000ABC 2
restore  78000000 0000005C 13572468 1 000000 00000000 - - 0000005C 13572468 1
flush    00CA5000 00000100 0 0        000000 00000000 12345678 12345678 00000100 - -
instr    B8000000 00000104 0 0        FFFFFF FFFFFFFF 00000000 00000000 00000104 - -
instr    78000000 00000108 0 0        000000 00000000 00000000 00000000 00000108 13572468 1

// File: files.f
hdl/decode_pkg.sv
hdl/special_reg_if.sv
hdl/reg_file_bypass.sv
hdl/special_regs.sv
hdl/control_decoder.sv
hdl/pipe_latch.sv
hdl/decode_stage.sv
bench/clk_gen.sv
bench/decode_tb.sv

// File: Makefile
VERILATOR  = verilator
FLAGS      = -sv --timing --assert
TOP        = decode_tb
FILELIST   = files.f
OBJ_DIR    = obj_dir
LOG        = sim.log
PASS_MSG   = === PASS ===

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q -- "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
